// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= fetch_unit_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test did not finish"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/branch_target_buff.sv
module branch_target_buff (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  fetch_pkg::addr_t     eip,
    input  btb_pkg::btb_update_t upd,
    output logic                 lookup_hit,
    output btb_pkg::btb_entry_t  lookup_entry
);

    import btb_pkg::*;

    // per-line storage
    logic [BTB_ENTRIES-1:0] valid_q;
    btb_tag_t               tag_q   [BTB_ENTRIES];
    btb_entry_t             entry_q [BTB_ENTRIES];

    btb_index_t rd_index;
    btb_tag_t   rd_tag;
    btb_index_t wr_index;
    btb_tag_t   wr_tag;
    logic       rd_match;

    assign rd_index = index_of(eip);        // lookup side
    assign rd_tag   = tag_of(eip);
    assign wr_index = index_of(upd.eip);    // update side
    assign wr_tag   = tag_of(upd.eip);

    // only the indexed line is compared
    assign rd_match = valid_q[rd_index] && (tag_q[rd_index] == rd_tag);

    assign lookup_hit   = rd_match;
    assign lookup_entry = rd_match ? entry_q[rd_index] : '0;   // zero on miss

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            valid_q <= '0;                   // flush beats a same-cycle write
        end else if (upd.valid) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd.valid) begin
            tag_q[wr_index]   <= wr_tag;     // overwrites whatever lived here
            entry_q[wr_index] <= upd.entry;
        end
    end

    // after a flush edge nothing may hit, even with a write pending
    a_flush_clears: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> (valid_q == '0)
    ) else $error("branch_target_buff: valid bit survived a flush");

    // a hit only ever returns data that was written clean
    a_hit_data_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        lookup_hit |-> !$isunknown(lookup_entry)
    ) else $error("branch_target_buff: hit with unknown entry data");

endmodule

// File: design/btb_pkg.sv
package btb_pkg;

    // direct-mapped table geometry
    localparam int BTB_ENTRIES = 64;
    localparam int INDEX_BITS  = 6;    // EIP[5:0]
    localparam int TAG_BITS    = 26;   // EIP[31:6]

    typedef logic [INDEX_BITS-1:0] btb_index_t;
    typedef logic [TAG_BITS-1:0]   btb_tag_t;

    // data stored per line next to its tag and valid bit
    typedef struct packed {
        fetch_pkg::addr_t target;
        fetch_pkg::addr_t fip_e;
        fetch_pkg::addr_t fip_o;
    } btb_entry_t;

    // one resolved branch on its way into the table
    typedef struct packed {
        logic             valid;   // write strobe
        fetch_pkg::addr_t eip;     // branch address picks line and tag
        btb_entry_t       entry;
    } btb_update_t;

    function automatic btb_index_t index_of(fetch_pkg::addr_t addr);
        return addr[INDEX_BITS-1:0];
    endfunction

    function automatic btb_tag_t tag_of(fetch_pkg::addr_t addr);
        return addr[INDEX_BITS +: TAG_BITS];
    endfunction

endpackage

// File: design/btb_update_stage.sv
module btb_update_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wb_valid,
    input  fetch_pkg::addr_t     wb_eip,
    input  fetch_pkg::addr_t     wb_target,
    input  fetch_pkg::addr_t     wb_fip_e,
    input  fetch_pkg::addr_t     wb_fip_o,
    output btb_pkg::btb_update_t upd
);

    import fetch_pkg::*;
    import btb_pkg::*;

    logic       valid_q;
    addr_t      eip_q;
    btb_entry_t entry_q;

    // strobe register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= wb_valid;   // one write per resolved branch
        end
    end

    // payload only moves when a branch arrives
    always_ff @(posedge clk) begin
        if (wb_valid) begin
            eip_q          <= wb_eip;
            entry_q.target <= wb_target;
            entry_q.fip_e  <= wb_fip_e;
            entry_q.fip_o  <= wb_fip_o;
        end
    end

    assign upd = '{valid: valid_q, eip: eip_q, entry: entry_q};

    // a write into the table must never carry X into tag or data
    a_upd_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        upd.valid |-> !$isunknown(upd)
    ) else $error("btb_update_stage: update fields unknown");

endmodule

// File: design/fetch_pc_stage.sv
module fetch_pc_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  logic                wb_redirect,
    input  fetch_pkg::addr_t    wb_redirect_eip,
    input  fetch_pkg::addr_t    reset_eip,
    input  logic                lookup_hit,
    input  btb_pkg::btb_entry_t lookup_entry,
    output fetch_pkg::addr_t    eip
);

    import fetch_pkg::*;

    addr_t eip_next;
    addr_t eip_seq;

    assign eip_seq = eip + FETCH_STEP;   // fall-through block

    // next-EIP selection
    //
    // A redirect from write-back corrects a wrong path and so beats
    // everything, including a stalled decoder. Otherwise the BTB
    // prediction for the current EIP steers the next fetch.
    always_comb begin
        if (wb_redirect) begin
            eip_next = wb_redirect_eip;      // mispredict or exception fixup
        end else if (stall) begin
            eip_next = eip;                  // decoder not ready
        end else if (lookup_hit) begin
            eip_next = lookup_entry.target;  // predicted taken
        end else begin
            eip_next = eip_seq;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            eip <= reset_eip;                // boot vector from outside
        end else begin
            eip <= eip_next;
        end
    end

    // EIP feeds the BTB index and the packet, so an X here spreads
    // through the whole front end
    a_eip_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(eip)
    ) else $error("fetch_pc_stage: EIP is unknown after reset");

endmodule

// File: design/fetch_pkg.sv
package fetch_pkg;

    // instruction address width used throughout the front end
    localparam int ADDR_BITS = 32;

    // EIP, branch targets and fetch line pointers all share this type
    typedef logic [ADDR_BITS-1:0] addr_t;

    // one fetch covers a 16 byte block
    localparam addr_t FETCH_STEP = 32'd16;

    // per-cycle result handed to the decoder
    //
    // target, fip_e and fip_o are only meaningful while hit is set.
    // They are zero on a miss because the BTB zeroes its read data then.
    typedef struct packed {
        logic  valid;    // packet carries a real fetch
        addr_t eip;      // address this packet was fetched from
        logic  hit;      // BTB predicted a taken branch here
        addr_t target;   // predicted next EIP
        addr_t fip_e;    // even fetch line of the target
        addr_t fip_o;    // odd fetch line of the target
    } fetch_pkt_t;

endpackage

// File: design/fetch_predict_stage.sv
module fetch_predict_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  fetch_pkg::addr_t      eip,
    input  logic                  lookup_hit,
    input  btb_pkg::btb_entry_t   lookup_entry,
    output fetch_pkg::fetch_pkt_t fetch_out
);

    import fetch_pkg::*;
    import btb_pkg::*;

    logic       valid_q;
    addr_t      eip_q;
    logic       hit_q;
    btb_entry_t entry_q;

    // valid comes up with the first accepted fetch and stays up
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            eip_q   <= eip;
            hit_q   <= lookup_hit;
            entry_q <= lookup_entry;   // already zero on a miss
        end
    end

    assign fetch_out = '{
        valid:  valid_q,
        eip:    eip_q,
        hit:    hit_q,
        target: entry_q.target,
        fip_e:  entry_q.fip_e,
        fip_o:  entry_q.fip_o
    };

endmodule

// File: design/fetch_unit_top.sv
module fetch_unit_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  wb_valid,
    input  fetch_pkg::addr_t      wb_eip,
    input  fetch_pkg::addr_t      wb_target,
    input  fetch_pkg::addr_t      wb_fip_e,
    input  fetch_pkg::addr_t      wb_fip_o,
    input  logic                  wb_redirect,
    input  fetch_pkg::addr_t      wb_redirect_eip,
    input  fetch_pkg::addr_t      reset_eip,
    output fetch_pkg::fetch_pkt_t fetch_out
);

    import fetch_pkg::*;
    import btb_pkg::*;

    addr_t       eip;            // current fetch pointer
    logic        lookup_hit;
    btb_entry_t  lookup_entry;
    btb_update_t upd;            // registered write-back branch

    fetch_pc_stage fetch_pc_stage_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall           (stall),
        .wb_redirect     (wb_redirect),
        .wb_redirect_eip (wb_redirect_eip),
        .reset_eip       (reset_eip),
        .lookup_hit      (lookup_hit),
        .lookup_entry    (lookup_entry),
        .eip             (eip)
    );

    branch_target_buff branch_target_buff_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .eip          (eip),
        .upd          (upd),
        .lookup_hit   (lookup_hit),
        .lookup_entry (lookup_entry)
    );

    btb_update_stage btb_update_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_valid  (wb_valid),
        .wb_eip    (wb_eip),
        .wb_target (wb_target),
        .wb_fip_e  (wb_fip_e),
        .wb_fip_o  (wb_fip_o),
        .upd       (upd)
    );

    fetch_predict_stage fetch_predict_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .eip          (eip),
        .lookup_hit   (lookup_hit),
        .lookup_entry (lookup_entry),
        .fetch_out    (fetch_out)
    );

endmodule

// File: src.f
design/fetch_pkg.sv
design/btb_pkg.sv
design/fetch_pc_stage.sv
design/branch_target_buff.sv
design/btb_update_stage.sv
design/fetch_predict_stage.sv
design/fetch_unit_top.sv
verif/fetch_unit_tb.sv

// File: verif/fetch_unit_tb.sv
module fetch_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import fetch_pkg::*;
    import btb_pkg::*;

    localparam int    RESET_CYCLES = 8;
    localparam int    RAND_PAIRS   = 8;
    localparam addr_t RESET_EIP    = 32'h0000_1000;

    typedef enum logic [2:0] {OP_RUN, OP_UPDATE, OP_REDIRECT, OP_STALL, OP_FLUSH} op_e;

    // one table step with the hit and target that redirect rows expect
    typedef struct packed {
        op_e   op;
        addr_t eip;          // branch, redirect or stall-redirect address
        addr_t target;
        logic  exp_hit;
        addr_t exp_target;
        int    cycles;
    } row_t;

    // DUT inputs for one clock cycle
    typedef struct packed {
        logic  stall;
        logic  flush;
        logic  wb_valid;
        addr_t wb_eip;
        addr_t wb_target;
        logic  wb_redirect;
        addr_t wb_redirect_eip;
    } stim_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       stall;
    logic       flush;
    logic       wb_valid;
    logic       wb_redirect;
    addr_t      wb_eip;
    addr_t      wb_target;
    addr_t      wb_fip_e;
    addr_t      wb_fip_o;
    addr_t      wb_redirect_eip;
    addr_t      reset_eip;
    fetch_pkt_t fetch_out;

    // reference array BTB with its fetch pointer, packet and update record
    logic        m_valid [BTB_ENTRIES];
    btb_tag_t    m_tag   [BTB_ENTRIES];
    btb_entry_t  m_entry [BTB_ENTRIES];
    addr_t       m_eip;
    fetch_pkt_t  m_pkt;
    btb_update_t m_upd;

    row_t        rows [$];
    logic [31:0] rng_state   = 32'd3083;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    fetch_unit_top fetch_unit_top_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall           (stall),
        .flush           (flush),
        .wb_valid        (wb_valid),
        .wb_eip          (wb_eip),
        .wb_target       (wb_target),
        .wb_fip_e        (wb_fip_e),
        .wb_fip_o        (wb_fip_o),
        .wb_redirect     (wb_redirect),
        .wb_redirect_eip (wb_redirect_eip),
        .reset_eip       (reset_eip),
        .fetch_out       (fetch_out)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("Simulation finished: FAIL");
            $fatal(1, "watchdog expired");
        end
    end

    // 32 byte fetch lines with the even line first
    function automatic addr_t even_line(addr_t a);
        return {a[31:6], 6'd0};
    endfunction

    function automatic addr_t odd_line(addr_t a);
        return {a[31:6], 6'd0} + 32'd32;
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic row_t make_row(op_e op, addr_t eip, addr_t target, logic exp_hit,
                                      addr_t exp_target, int cycles);
        row_t r;
        r.op         = op;
        r.eip        = eip;
        r.target     = target;
        r.exp_hit    = exp_hit;
        r.exp_target = exp_target;
        r.cycles     = cycles;
        return r;
    endfunction

    task automatic check_pkt(input string name, input fetch_pkt_t exp, input fetch_pkt_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1, "packet mismatch");
        end
    endtask

    task automatic check_eip(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b actual %b", name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic drive_inputs(input stim_t s);
        stall           = s.stall;
        flush           = s.flush;
        wb_valid        = s.wb_valid;
        wb_eip          = s.wb_eip;
        wb_target       = s.wb_target;
        wb_fip_e        = even_line(s.wb_target);
        wb_fip_o        = odd_line(s.wb_target);
        wb_redirect     = s.wb_redirect;
        wb_redirect_eip = s.wb_redirect_eip;
    endtask

    task automatic model_reset();
        m_eip = RESET_EIP;
        m_pkt = '0;
        m_upd = '0;
        foreach (m_valid[i]) m_valid[i] = 1'b0;
    endtask

    // one clock edge of the reference with lookups on pre-edge state
    task automatic model_step(input stim_t s);
        btb_index_t idx;
        logic       hit;
        btb_entry_t entry;
        idx   = m_eip[INDEX_BITS-1:0];
        hit   = m_valid[idx] && (m_tag[idx] == m_eip[ADDR_BITS-1:INDEX_BITS]);
        entry = hit ? m_entry[idx] : '0;
        if (!s.stall) begin
            m_pkt = '{valid: 1'b1, eip: m_eip, hit: hit, target: entry.target,
                      fip_e: entry.fip_e, fip_o: entry.fip_o};
        end
        if (s.wb_redirect) m_eip = s.wb_redirect_eip;
        else if (!s.stall) m_eip = hit ? entry.target : m_eip + FETCH_STEP;
        if (s.flush) begin
            foreach (m_valid[i]) m_valid[i] = 1'b0;   // flush wins over the write
        end else if (m_upd.valid) begin
            idx          = m_upd.eip[INDEX_BITS-1:0];
            m_valid[idx] = 1'b1;
            m_tag[idx]   = m_upd.eip[ADDR_BITS-1:INDEX_BITS];
            m_entry[idx] = m_upd.entry;
        end
        m_upd.valid = s.wb_valid;
        if (s.wb_valid) begin
            m_upd.eip   = s.wb_eip;
            m_upd.entry = '{target: s.wb_target, fip_e: even_line(s.wb_target),
                            fip_o: odd_line(s.wb_target)};
        end
    endtask

    task automatic step_cycle(input stim_t s, input string name);
        drive_inputs(s);
        @(posedge clk);
        #2;
        model_step(s);
        check_pkt(name, m_pkt, fetch_out);
        check_eip({name, " eip"}, m_eip, fetch_unit_top_inst.eip);
    endtask

    task automatic apply_row(input row_t r, input int num);
        stim_t s;
        op_e   op;
        string name;
        op   = r.op;
        name = $sformatf("row %0d %s", num, op.name());
        for (int c = 0; c < r.cycles; c++) begin
            s       = '0;
            s.stall = (op == OP_STALL);
            if (c == 0) begin
                case (op)
                    OP_UPDATE: begin
                        s.wb_valid  = 1'b1;
                        s.wb_eip    = r.eip;
                        s.wb_target = r.target;
                    end
                    OP_REDIRECT, OP_STALL: begin
                        s.wb_redirect     = (r.eip != '0);   // a stall row may redirect too
                        s.wb_redirect_eip = r.eip;
                    end
                    OP_FLUSH: s.flush = 1'b1;
                    default: s = s;
                endcase
            end
            step_cycle(s, name);
            if (op == OP_REDIRECT && c == 1) begin   // packet of the redirect EIP
                check_eip({name, " pkt eip"}, r.eip, fetch_out.eip);
                check_bit({name, " hit"}, r.exp_hit, fetch_out.hit);
                if (r.exp_hit) begin
                    check_eip({name, " target"}, r.exp_target, fetch_out.target);
                    check_eip({name, " fip_e"}, even_line(r.exp_target), fetch_out.fip_e);
                    check_eip({name, " fip_o"}, odd_line(r.exp_target), fetch_out.fip_o);
                end
            end
            if (op == OP_REDIRECT && c == 2 && r.exp_hit) begin
                check_eip({name, " next eip"}, r.exp_target, fetch_out.eip);
            end
        end
    endtask

    task automatic add_directed_rows();
        // every fetch falls through while the table is cold
        rows.push_back(make_row(OP_RUN, '0, '0, 1'b0, '0, 3));
        rows.push_back(make_row(OP_REDIRECT, 32'h0000_2000, '0, 1'b0, '0, 4));
        rows.push_back(make_row(OP_UPDATE, 32'h0000_3008, 32'h0000_8040, 1'b0, '0, 3));
        rows.push_back(make_row(OP_REDIRECT, 32'h0000_3008, '0, 1'b1, 32'h0000_8040, 4));
        // same index, other tag, then replacement
        rows.push_back(make_row(OP_REDIRECT, 32'h0001_3008, '0, 1'b0, '0, 3));
        rows.push_back(make_row(OP_UPDATE, 32'h0005_0008, 32'h0000_A000, 1'b0, '0, 3));
        rows.push_back(make_row(OP_REDIRECT, 32'h0000_3008, '0, 1'b0, '0, 3));
        rows.push_back(make_row(OP_REDIRECT, 32'h0005_0008, '0, 1'b1, 32'h0000_A000, 4));
        rows.push_back(make_row(OP_UPDATE, 32'h0000_4010, 32'h0000_C000, 1'b0, '0, 3));
        rows.push_back(make_row(OP_REDIRECT, 32'h0000_4010, '0, 1'b1, 32'h0000_C000, 4));
        rows.push_back(make_row(OP_FLUSH, '0, '0, 1'b0, '0, 2));
        rows.push_back(make_row(OP_REDIRECT, 32'h0000_4010, '0, 1'b0, '0, 3));
        rows.push_back(make_row(OP_REDIRECT, 32'h0005_0008, '0, 1'b0, '0, 3));
        // one-cycle update row puts the flush on the table write edge
        rows.push_back(make_row(OP_UPDATE, 32'h0000_6020, 32'h0000_D000, 1'b0, '0, 1));
        rows.push_back(make_row(OP_FLUSH, '0, '0, 1'b0, '0, 2));
        rows.push_back(make_row(OP_REDIRECT, 32'h0000_6020, '0, 1'b0, '0, 3));
        rows.push_back(make_row(OP_UPDATE, 32'h0000_7000, 32'h0000_E000, 1'b0, '0, 3));
        rows.push_back(make_row(OP_STALL, '0, '0, 1'b0, '0, 5));
        rows.push_back(make_row(OP_RUN, '0, '0, 1'b0, '0, 3));
        rows.push_back(make_row(OP_STALL, 32'h0000_7000, '0, 1'b0, '0, 5));
        rows.push_back(make_row(OP_RUN, '0, '0, 1'b0, '0, 4));
        rows.push_back(make_row(OP_REDIRECT, 32'h0000_7000, '0, 1'b1, 32'h0000_E000, 4));
    endtask

    task automatic add_random_rows();
        addr_t eip;
        addr_t target;
        for (int i = 0; i < RAND_PAIRS; i++) begin
            rng_state = xorshift(rng_state);
            eip       = rng_state;
            rng_state = xorshift(rng_state);
            target    = rng_state;
            rows.push_back(make_row(OP_UPDATE, eip, target, 1'b0, '0, 3));
            rows.push_back(make_row(OP_REDIRECT, eip, '0, 1'b1, target, 4));
        end
    endtask

    task automatic add_closing_rows();
        rows.push_back(make_row(OP_FLUSH, '0, '0, 1'b0, '0, 2));
        rows.push_back(make_row(OP_REDIRECT, RESET_EIP, '0, 1'b0, '0, 3));
    endtask

    initial begin
        rst_n     = 1'b0;
        reset_eip = RESET_EIP;
        drive_inputs('0);
        add_directed_rows();
        add_random_rows();
        add_closing_rows();
        cycle_limit = rows.size() * 6 + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_bit("reset valid", 1'b0, fetch_out.valid);   // no packet out of reset
        model_reset();
        foreach (rows[i]) apply_row(rows[i], i);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
